// File: Makefile
# Verilator build and run for the float16 convolution engine

VERILATOR ?= verilator
TOP       ?= conv_para9_float16_tb
FILELIST  ?= conv_para9_float16.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: conv_para9_float16.f
design/fp16_pkg.sv
design/conv_pkg.sv
design/fp16_mul.sv
design/fp16_add.sv
design/fp16_mac_unit.sv
design/conv_sequencer.sv
design/conv_para9_float16.sv
test/conv_para9_float16_checker.sv
test/conv_para9_float16_tb.sv

// File: design/conv_para9_float16.sv
module conv_para9_float16 (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  logic [conv_pkg::row_units*fp16_pkg::data_width-1:0]     fm_1,
    input  logic [conv_pkg::row_units*fp16_pkg::data_width-1:0]     fm_2,
    input  logic [conv_pkg::row_units*fp16_pkg::data_width-1:0]     fm_3,
    input  logic [fp16_pkg::data_width-1:0]                         weight,
    input  logic [conv_pkg::clk_num_width-1:0]                      clk_num,
    output logic                                                    result_ready,
    output logic [conv_pkg::ret_size-1:0]                           result_buffer
);

    logic first;
    logic last;
    logic [conv_pkg::row_units*fp16_pkg::data_width-1:0] fm_rows [conv_pkg::row_units];

    conv_sequencer i_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .clk_num      (clk_num),
        .first        (first),
        .last         (last),
        .result_ready (result_ready)
    );

    // Row r of the window comes in on bus fm_(r+1)
    assign fm_rows[0] = fm_1;
    assign fm_rows[1] = fm_2;
    assign fm_rows[2] = fm_3;

    ////////////////////////////////////////
    // MAC array
    ////////////////////////////////////////

    for (genvar k = 0; k < conv_pkg::unit_num; k++) begin : g_unit
        logic [fp16_pkg::data_width-1:0] fm_unit;
        logic [fp16_pkg::data_width-1:0] unit_result;

        // Unit r*3 + c takes value c of row r
        assign fm_unit = fm_rows[k / conv_pkg::row_units]
                                [(k % conv_pkg::row_units) * fp16_pkg::data_width
                                 +: fp16_pkg::data_width];

        fp16_mac_unit i_mac (
            .clk    (clk),
            .rst_n  (rst_n),
            .first  (first),
            .last   (last),
            .fm     (fm_unit),
            .weight (weight),
            .result (unit_result)
        );

        assign result_buffer[k*fp16_pkg::data_width +: fp16_pkg::data_width] = unit_result;
    end

endmodule

// File: design/conv_pkg.sv
package conv_pkg;

    ////////////////////////////////////////
    // Convolution array
    ////////////////////////////////////////

    // One MAC unit per output position of a 3x3 window
    localparam int unit_num = 9;

    // Values carried on each fm bus
    localparam int row_units = 3;

    // Width of the window length input
    localparam int clk_num_width = 8;

    // Nine float16 sums side by side
    localparam int ret_size = unit_num * fp16_pkg::data_width;

endpackage

// File: design/conv_sequencer.sv
module conv_sequencer (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [conv_pkg::clk_num_width-1:0] clk_num,
    output logic                               first,
    output logic                               last,
    output logic                               result_ready
);

    logic [conv_pkg::clk_num_width-1:0] cnt;
    logic [conv_pkg::clk_num_width-1:0] clk_num_lat;
    logic [conv_pkg::clk_num_width-1:0] clk_num_cur;

    // Sample index 0 opens a window
    assign first = (cnt == '0);

    // Window length taken live at sample 0, latched copy afterwards
    assign clk_num_cur = first ? clk_num : clk_num_lat;
    assign last        = (cnt == clk_num_cur);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt          <= '0;
            clk_num_lat  <= '0;
            result_ready <= 1'b0;
        end else begin
            result_ready <= last;
            if (first) begin
                clk_num_lat <= clk_num;
            end
            // Wrap straight into the next window
            if (last) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// File: design/fp16_add.sv
module fp16_add (
    input  logic [fp16_pkg::data_width-1:0] a,
    input  logic [fp16_pkg::data_width-1:0] b,
    output logic [fp16_pkg::data_width-1:0] s
);

    logic [fp16_pkg::data_width-2:0]   mag_a;
    logic [fp16_pkg::data_width-2:0]   mag_b;
    logic                              swap;
    logic [fp16_pkg::data_width-1:0]   op_big;
    logic [fp16_pkg::data_width-1:0]   op_small;
    logic [fp16_pkg::exp_width-1:0]    exp_big;
    logic [fp16_pkg::exp_width-1:0]    exp_small;
    logic [fp16_pkg::exp_width-1:0]    shift;
    logic [fp16_pkg::sig_width-1:0]    sig_big;
    logic [fp16_pkg::sig_width-1:0]    sig_small;
    logic [fp16_pkg::add_width-1:0]    ext_big;
    logic [fp16_pkg::add_width-1:0]    ext_small;
    logic [fp16_pkg::add_width-1:0]    sum_ext;
    logic [fp16_pkg::add_width-1:0]    norm;
    logic [fp16_pkg::man_width-1:0]    man;
    logic                              sign;
    logic                              subtract;
    int                                lzc;
    int                                exp_res;

    ////////////////////////////////////////
    // Operand ordering
    ////////////////////////////////////////

    // Subnormals are flushed to zero magnitude first
    assign mag_a = (a[fp16_pkg::exp_msb:fp16_pkg::exp_lsb] == '0)
                 ? '0 : a[fp16_pkg::data_width-2:0];
    assign mag_b = (b[fp16_pkg::exp_msb:fp16_pkg::exp_lsb] == '0)
                 ? '0 : b[fp16_pkg::data_width-2:0];

    assign swap     = mag_b > mag_a;
    assign op_big   = swap ? {b[fp16_pkg::sign_bit], mag_b} : {a[fp16_pkg::sign_bit], mag_a};
    assign op_small = swap ? {a[fp16_pkg::sign_bit], mag_a} : {b[fp16_pkg::sign_bit], mag_b};

    assign exp_big   = op_big[fp16_pkg::exp_msb:fp16_pkg::exp_lsb];
    assign exp_small = op_small[fp16_pkg::exp_msb:fp16_pkg::exp_lsb];

    // Zero magnitude has no hidden bit
    assign sig_big   = (exp_big == '0)
                     ? '0 : {1'b1, op_big[fp16_pkg::man_width-1:0]};
    assign sig_small = (exp_small == '0)
                     ? '0 : {1'b1, op_small[fp16_pkg::man_width-1:0]};

    // Ordered by magnitude, so exp_big is never below exp_small
    assign shift = exp_big - exp_small;

    ////////////////////////////////////////
    // Exact alignment and sum
    ////////////////////////////////////////

    assign ext_big   = {1'b0, sig_big, {(fp16_pkg::add_width-fp16_pkg::sig_width-1){1'b0}}};
    assign ext_small = {1'b0, sig_small, {(fp16_pkg::add_width-fp16_pkg::sig_width-1){1'b0}}}
                       >> shift;

    assign subtract = op_big[fp16_pkg::sign_bit] ^ op_small[fp16_pkg::sign_bit];
    assign sum_ext  = subtract ? ext_big - ext_small : ext_big + ext_small;

    // Larger operand decides the sign
    assign sign = op_big[fp16_pkg::sign_bit];

    // Leading zero count, lowest set bit scanned first
    always_comb begin
        lzc = fp16_pkg::add_width;
        for (int i = 0; i < fp16_pkg::add_width; i++) begin
            if (sum_ext[i]) begin
                lzc = fp16_pkg::add_width - 1 - i;
            end
        end
    end

    // Leading one moves to the top bit
    assign norm = sum_ext << lzc;
    assign man  = norm[fp16_pkg::add_width-2 -: fp16_pkg::man_width];

    // Hidden bit sits one below the carry bit when lzc is 1
    assign exp_res = int'(exp_big) + 1 - lzc;

    ////////////////////////////////////////
    // Result packing
    ////////////////////////////////////////

    always_comb begin
        if (sum_ext == '0) begin
            // Exact cancellation
            s = fp16_pkg::pos_zero;
        end else if (exp_res <= 0) begin
            s = {sign, {(fp16_pkg::data_width-1){1'b0}}};
        end else if (exp_res >= int'(fp16_pkg::exp_max)) begin
            s = {sign, fp16_pkg::exp_max, {fp16_pkg::man_width{1'b0}}};
        end else begin
            s = {sign, exp_res[fp16_pkg::exp_width-1:0], man};
        end
    end

endmodule

// File: design/fp16_mac_unit.sv
module fp16_mac_unit (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            first,
    input  logic                            last,
    input  logic [fp16_pkg::data_width-1:0] fm,
    input  logic [fp16_pkg::data_width-1:0] weight,
    output logic [fp16_pkg::data_width-1:0] result
);

    logic [fp16_pkg::data_width-1:0] prod;
    logic [fp16_pkg::data_width-1:0] sum;
    logic [fp16_pkg::data_width-1:0] acc;
    logic [fp16_pkg::data_width-1:0] acc_next;

    fp16_mul i_mul (
        .a (fm),
        .b (weight),
        .p (prod)
    );

    fp16_add i_add (
        .a (acc),
        .b (prod),
        .s (sum)
    );

    // First sample of a window starts a fresh sum
    assign acc_next = first ? prod : sum;

    always_ff @(posedge clk) begin
        acc <= acc_next;
    end

    // Completed window value, held until the next window closes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= fp16_pkg::pos_zero;
        end else if (last) begin
            result <= acc_next;
        end
    end

endmodule

// File: design/fp16_mul.sv
module fp16_mul (
    input  logic [fp16_pkg::data_width-1:0] a,
    input  logic [fp16_pkg::data_width-1:0] b,
    output logic [fp16_pkg::data_width-1:0] p
);

    logic                              sign;
    logic [fp16_pkg::exp_width-1:0]    exp_a;
    logic [fp16_pkg::exp_width-1:0]    exp_b;
    logic [fp16_pkg::sig_width-1:0]    sig_a;
    logic [fp16_pkg::sig_width-1:0]    sig_b;
    logic [fp16_pkg::prod_width-1:0]   prod;
    logic [fp16_pkg::man_width-1:0]    man;
    logic                              zero_in;
    logic                              carry;
    int                                exp_sum;

    assign sign  = a[fp16_pkg::sign_bit] ^ b[fp16_pkg::sign_bit];
    assign exp_a = a[fp16_pkg::exp_msb:fp16_pkg::exp_lsb];
    assign exp_b = b[fp16_pkg::exp_msb:fp16_pkg::exp_lsb];

    // Subnormal operands count as zero
    assign zero_in = (exp_a == '0) || (exp_b == '0);

    assign sig_a = {1'b1, a[fp16_pkg::man_width-1:0]};
    assign sig_b = {1'b1, b[fp16_pkg::man_width-1:0]};

    // Product lies in [1, 4), binary point below the top two bits
    assign prod  = sig_a * sig_b;
    assign carry = prod[fp16_pkg::prod_width-1];

    // Normalise by one place when the product reached 2 or more
    assign man = carry ? prod[fp16_pkg::prod_width-2 -: fp16_pkg::man_width]
                       : prod[fp16_pkg::prod_width-3 -: fp16_pkg::man_width];

    assign exp_sum = int'(exp_a) + int'(exp_b) - fp16_pkg::exp_bias + int'(carry);

    ////////////////////////////////////////
    // Result packing
    ////////////////////////////////////////

    always_comb begin
        if (zero_in || exp_sum <= 0) begin
            // Zero operand or underflow, keep the sign
            p = {sign, {(fp16_pkg::data_width-1){1'b0}}};
        end else if (exp_sum >= int'(fp16_pkg::exp_max)) begin
            p = {sign, fp16_pkg::exp_max, {fp16_pkg::man_width{1'b0}}};
        end else begin
            // Low product bits dropped, truncation toward zero
            p = {sign, exp_sum[fp16_pkg::exp_width-1:0], man};
        end
    end

endmodule

// File: design/fp16_pkg.sv
package fp16_pkg;

    ////////////////////////////////////////
    // Word format
    ////////////////////////////////////////

    // One IEEE half-precision word
    localparam int data_width = 16;
    localparam int exp_width = 5;

    // Stored mantissa, hidden bit not included
    localparam int man_width = 10;
    localparam int exp_bias = 15;

    // Field positions inside a word
    localparam int sign_bit = data_width - 1;
    localparam int exp_msb = sign_bit - 1;
    localparam int exp_lsb = man_width;

    ////////////////////////////////////////
    // Special encodings
    ////////////////////////////////////////

    // All-ones exponent, mantissa zero gives infinity
    localparam logic [exp_width-1:0] exp_max = '1;

    // Positive zero
    localparam logic [data_width-1:0] pos_zero = '0;

    ////////////////////////////////////////
    // Datapath widths
    ////////////////////////////////////////

    // Significand with the hidden bit
    localparam int sig_width = man_width + 1;

    // Full product of two significands
    localparam int prod_width = 2 * sig_width;

    // Carry bit, big significand and room below it for the
    // largest alignment shift, so a sum is exact before truncation
    localparam int add_width = sig_width + 2 ** exp_width;

endpackage

// File: test/conv_para9_float16_checker.sv
module conv_para9_float16_checker (
    input logic                               clk,
    input logic                               rst_n,
    input logic                               first,
    input logic [conv_pkg::clk_num_width-1:0] clk_num,
    input logic                               result_ready,
    input logic [conv_pkg::ret_size-1:0]      result_buffer
);

    logic [conv_pkg::clk_num_width-1:0] clk_num_lat;

    // Window length as held for the running window
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_num_lat <= '0;
        end else if (first) begin
            clk_num_lat <= clk_num;
        end
    end

    ////////////////////////////////////////
    // Result protocol
    ////////////////////////////////////////

    // Back to back pulses only for one-sample windows
    assert property (@(posedge clk) disable iff (!rst_n)
        result_ready |=> !result_ready || (clk_num_lat == '0))
        else $error("result_ready high in two cycles with a window longer than one sample");

    assert property (@(posedge clk) !rst_n |=> !result_ready)
        else $error("result_ready high right after reset");

    assert property (@(posedge clk) disable iff (!rst_n)
        !result_ready |-> $stable(result_buffer))
        else $error("result_buffer changed without result_ready");

endmodule

bind conv_para9_float16 conv_para9_float16_checker i_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .first         (first),
    .clk_num       (clk_num),
    .result_ready  (result_ready),
    .result_buffer (result_buffer)
);

// File: test/conv_para9_float16_tb.sv
module conv_para9_float16_tb;

    typedef logic [fp16_pkg::data_width-1:0] word_t;
    typedef logic [conv_pkg::ret_size-1:0]   result_t;

    localparam int clk_period      = 40;
    localparam int reset_cycles    = 3;
    localparam int num_random      = 15;
    localparam int partial_samples = 4;

    // Stimulus kinds of one window
    localparam int mode_int      = 0;
    localparam int mode_rand     = 1;
    localparam int mode_cancel   = 2;
    localparam int mode_tiny     = 3;
    localparam int mode_overflow = 4;

    logic                                                clk = 1'b0;
    logic                                                rst_n;
    logic [conv_pkg::row_units*fp16_pkg::data_width-1:0] fm_1;
    logic [conv_pkg::row_units*fp16_pkg::data_width-1:0] fm_2;
    logic [conv_pkg::row_units*fp16_pkg::data_width-1:0] fm_3;
    word_t                                               weight;
    logic [conv_pkg::clk_num_width-1:0]                  clk_num;
    logic                                                result_ready;
    result_t                                             result_buffer;

    integer  seed;
    int      value_errors = 0;
    int      protocol_errors = 0;
    int      since_pulse = 0;
    bit      after_reset = 1'b1;
    result_t want_word;
    int      want_len;
    result_t expected_q [$];
    int      len_q [$];

    conv_para9_float16 i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .fm_1          (fm_1),
        .fm_2          (fm_2),
        .fm_3          (fm_3),
        .weight        (weight),
        .clk_num       (clk_num),
        .result_ready  (result_ready),
        .result_buffer (result_buffer)
    );

    always #(clk_period / 2) clk = ~clk;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Exact value in units of 2^-24, subnormals count as zero
    function automatic longint to_fixed(input word_t x);
        longint mag;
        if (x[14:10] == 5'd0) begin
            return 0;
        end
        mag = {1'b1, x[9:0]};
        mag = mag << (int'(x[14:10]) - 1);
        return x[15] ? -mag : mag;
    endfunction

    // Magnitude mag * 2^scale, truncated to a word
    function automatic word_t fp16_pack(input logic sign, input longint mag, input int scale);
        int         msb;
        int         e;
        logic [9:0] man;
        msb = 0;
        for (int i = 0; i < 64; i++) begin
            if (mag[i]) begin
                msb = i;
            end
        end
        e = msb + scale + 15;
        if (e <= 0) begin
            return {sign, 15'd0};
        end
        if (e >= 31) begin
            return {sign, 5'h1f, 10'd0};
        end
        if (msb >= 10) begin
            man = 10'(mag >> (msb - 10));
        end else begin
            man = 10'(mag << (10 - msb));
        end
        return {sign, 5'(e), man};
    endfunction

    function automatic word_t fp16_mul_ref(input word_t a, input word_t b);
        logic   sign;
        longint sa;
        longint sb;
        sign = a[15] ^ b[15];
        if (a[14:10] == 5'd0 || b[14:10] == 5'd0) begin
            return {sign, 15'd0};
        end
        sa = {1'b1, a[9:0]};
        sb = {1'b1, b[9:0]};
        return fp16_pack(sign, sa * sb, int'(a[14:10]) + int'(b[14:10]) - 50);
    endfunction

    // An infinity left by overflow is taken at its exponent value
    function automatic word_t fp16_add_ref(input word_t a, input word_t b);
        longint sum;
        sum = to_fixed(a) + to_fixed(b);
        if (sum == 0) begin
            return fp16_pkg::pos_zero;
        end
        if (sum < 0) begin
            return fp16_pack(1'b1, -sum, -24);
        end
        return fp16_pack(1'b0, sum, -24);
    endfunction

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    // Normal words with small exponents, about one in sixteen a zero
    function automatic word_t rand_fp16();
        logic [31:0] r;
        r = $random(seed);
        if (r[3:0] == 4'd0) begin
            return {r[31], 15'd0};
        end
        return {r[31], 5'd12 + {2'b00, r[6:4]}, r[25:16]};
    endfunction

    // 1.0, 2.0, 3.0, 4.0 in turn
    function automatic word_t int_value(input int idx);
        case (idx % 4)
            0:       return 16'h3c00;
            1:       return 16'h4000;
            2:       return 16'h4200;
            default: return 16'h4400;
        endcase
    endfunction

    function automatic int window_len(input int idx);
        case (idx % 5)
            0:       return 8;
            1:       return 3;
            2:       return 0;
            3:       return 0;
            default: return 5;
        endcase
    endfunction

    function automatic int total_cycles();
        int sum;
        sum = 2 * reset_cycles + 2 * 9 + 2 + 2 + 3 + partial_samples;
        for (int i = 0; i < num_random; i++) begin
            sum += window_len(i) + 1;
        end
        return sum;
    endfunction

    task automatic check_value(input string name, input result_t got, input result_t want);
        if (got !== want) begin
            value_errors++;
            $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, want);
        end
    endtask

    task automatic apply_reset();
        rst_n <= 1'b0;
        @(negedge clk);
        check_value("result_ready", result_ready, '0);
        check_value("result_buffer", result_buffer, '0);
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic drive_sample(input word_t vals [conv_pkg::unit_num], input word_t w,
                                input int n);
        fm_1    <= {vals[2], vals[1], vals[0]};
        fm_2    <= {vals[5], vals[4], vals[3]};
        fm_3    <= {vals[8], vals[7], vals[6]};
        weight  <= w;
        clk_num <= 8'(n);
    endtask

    // Drives one whole window and queues its nine sums
    task automatic run_window(input int n, input int mode);
        word_t       vals [conv_pkg::unit_num];
        word_t       keep [conv_pkg::unit_num];
        word_t       acc [conv_pkg::unit_num];
        word_t       w;
        word_t       prod;
        logic [31:0] r;
        result_t     want;
        for (int i = 0; i <= n; i++) begin
            for (int k = 0; k < conv_pkg::unit_num; k++) begin
                r = $random(seed);
                case (mode)
                    mode_int:  vals[k] = int_value(k + i);
                    mode_rand: vals[k] = rand_fp16();
                    mode_cancel: begin
                        if (i == 0) begin
                            keep[k] = rand_fp16();
                        end
                        vals[k] = (i == 0) ? keep[k] : {~keep[k][15], keep[k][14:0]};
                    end
                    mode_tiny: begin
                        // Last unit gets a subnormal
                        vals[k] = (k == 8) ? 16'h8155 : {k[0], 5'd1, r[9:0]};
                    end
                    default: vals[k] = {k[0], 5'd28 + {4'd0, r[0]}, r[25:16]};
                endcase
            end
            r = $random(seed);
            case (mode)
                mode_int:    w = i[0] ? 16'h4000 : 16'h3c00;
                mode_rand:   w = rand_fp16();
                mode_cancel: w = 16'h3c00;
                mode_tiny:   w = {r[31], 5'd2, r[19:10]};
                default:     w = {1'b0, 5'd20, r[9:0]};
            endcase
            drive_sample(vals, w, n);
            for (int k = 0; k < conv_pkg::unit_num; k++) begin
                prod   = fp16_mul_ref(vals[k], w);
                acc[k] = (i == 0) ? prod : fp16_add_ref(acc[k], prod);
            end
            @(posedge clk);
        end
        for (int k = 0; k < conv_pkg::unit_num; k++) begin
            want[k*16 +: 16] = acc[k];
        end
        expected_q.push_back(want);
        len_q.push_back(n);
    endtask

    // Window cut short by a reset, nothing queued
    task automatic run_partial();
        word_t vals [conv_pkg::unit_num];
        for (int i = 0; i < partial_samples; i++) begin
            for (int k = 0; k < conv_pkg::unit_num; k++) begin
                vals[k] = rand_fp16();
            end
            drive_sample(vals, rand_fp16(), 8);
            @(posedge clk);
        end
    endtask

    ////////////////////////////////////////
    // Result comparison
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst_n) begin
            since_pulse = 0;
            after_reset = 1'b1;
        end else begin
            since_pulse++;
            if (result_ready) begin
                if (expected_q.size() == 0) begin
                    protocol_errors++;
                    $display("ERROR at %0t: result_ready came with no window result pending",
                             $time);
                end else begin
                    want_word = expected_q.pop_front();
                    want_len  = len_q.pop_front();
                    // One extra cycle from reset release to sample 0
                    check_value("result_ready spacing", result_t'(since_pulse),
                                result_t'(want_len + 1 + int'(after_reset)));
                    for (int k = 0; k < conv_pkg::unit_num; k++) begin
                        check_value($sformatf("result_buffer[%0d]", k),
                                    result_t'(result_buffer[k*16 +: 16]),
                                    result_t'(want_word[k*16 +: 16]));
                    end
                end
                since_pulse = 0;
                after_reset = 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        seed    = 32'h0e02_fdbd;
        rst_n   = 1'b0;
        fm_1    = '0;
        fm_2    = '0;
        fm_3    = '0;
        weight  = '0;
        clk_num = '0;
        apply_reset();
        run_window(8, mode_int);
        for (int i = 0; i < num_random; i++) begin
            run_window(window_len(i), mode_rand);
        end
        run_window(1, mode_cancel);
        run_window(0, mode_tiny);
        run_window(0, mode_tiny);
        run_window(2, mode_overflow);
        run_partial();
        apply_reset();
        run_window(8, mode_int);
        // Longest window keeps further results away until the end
        clk_num <= '1;
        while (expected_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        $display("Errors: %0d value mismatches, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #((total_cycles() + 20) * clk_period);
        protocol_errors++;
        $display("Timeout: run did not finish, %0d expected results never arrived",
                 expected_q.size());
        $display("Errors: %0d value mismatches, %0d protocol errors",
                 value_errors, protocol_errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule
